//--- source/mesh_pkg.sv
`default_nettype none

package mesh_pkg;

    // up to an 8x8 mesh
    parameter int COORD_W = 3;

    typedef logic [COORD_W-1:0] coord_t;

    // router port numbering, also the bit index into a port mask
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_e;

    typedef logic [4:0] port_mask_t;   // indexed by port_e

    // destination relative to the current router
    // y grows toward SOUTH, so y_min means a NORTH move
    typedef struct packed {
        logic x_plus;
        logic x_min;
        logic y_plus;
        logic y_min;
        logic same_x;
        logic same_y;
    } dir_t;

    // coded destination port
    typedef struct packed {
        logic x;   // east bound
        logic y;   // north bound
        logic a;   // an x port is permitted
        logic b;   // a y port is permitted
    } dest_code_t;

endpackage

`default_nettype wire

//--- source/route_pkg.sv
`default_nettype none

package route_pkg;

    parameter int TAG_W = 4;

    typedef enum logic [2:0] {
        ALGO_XY         = 3'd0,
        ALGO_WEST_FIRST = 3'd1,
        ALGO_NORTH_LAST = 3'd2,
        ALGO_NEG_FIRST  = 3'd3,
        ALGO_ODD_EVEN   = 3'd4
    } algo_e;

    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_CALC = 2'd1,   // two pipeline stages in flight
        LANE_DONE = 2'd2    // result held until drained
    } lane_state_e;

    // one routing request
    typedef struct packed {
        algo_e              algo;
        mesh_pkg::coord_t   cur_x;
        mesh_pkg::coord_t   cur_y;
        mesh_pkg::coord_t   dst_x;
        mesh_pkg::coord_t   dst_y;
        logic [TAG_W-1:0]   tag;
    } route_req_t;

    // one routing response
    typedef struct packed {
        logic [TAG_W-1:0]     tag;
        mesh_pkg::port_mask_t ports;
        mesh_pkg::dest_code_t code;
    } route_rsp_t;

endpackage

`default_nettype wire

//--- source/route_algo.sv
`default_nettype none

module route_algo #(
    parameter int ni_routing = 0
) (
    input  route_pkg::algo_e     algo,
    input  mesh_pkg::coord_t     cur_x,
    input  mesh_pkg::coord_t     dst_x,
    input  mesh_pkg::dir_t       dir,
    output mesh_pkg::port_mask_t ports,
    output mesh_pkg::dest_code_t code
);
    import mesh_pkg::*;
    import route_pkg::*;

    port_e      x_port;    // x port toward the destination
    port_e      y_port;    // y port toward the destination
    logic       one_step;  // destination is the next column east
    port_mask_t mask;

    assign one_step = (coord_t'(dst_x - cur_x) == coord_t'(1));

    always_comb begin
        if (dir.x_plus) begin
            x_port = EAST;
        end else begin
            x_port = WEST;
        end
        if (dir.y_min) begin
            y_port = NORTH;
        end else begin
            y_port = SOUTH;
        end
    end

    always_comb begin
        mask = '0;
        if (dir.same_x && dir.same_y) begin
            mask[LOCAL] = 1'b1;
        end else if (dir.same_x) begin
            mask[y_port] = 1'b1;          // straight, any algorithm
        end else if (dir.same_y) begin
            mask[x_port] = 1'b1;
        end else begin
            // diagonal moves, turn rules differ per algorithm
            case (algo)
                ALGO_WEST_FIRST: begin
                    mask[x_port] = 1'b1;
                    if (dir.x_plus) mask[y_port] = 1'b1;   // west goes first, alone
                end
                ALGO_NORTH_LAST: begin
                    mask[x_port] = 1'b1;
                    mask[SOUTH]  = dir.y_plus;   // north only once x is done
                end
                ALGO_NEG_FIRST: begin
                    // no east when heading south-east
                    if (!(dir.x_plus && dir.y_plus)) mask[x_port] = 1'b1;
                    // no north when heading north-west
                    if (dir.x_plus || dir.y_plus) mask[y_port] = 1'b1;
                end
                ALGO_ODD_EVEN: begin
                    if (dir.x_plus) begin
                        // turn out of east only in odd columns
                        if (cur_x[0] || ni_routing != 0) mask[y_port] = 1'b1;
                        if (dst_x[0] || !one_step) mask[EAST] = 1'b1;
                    end else begin
                        mask[WEST] = 1'b1;
                        if (!cur_x[0]) mask[y_port] = 1'b1;   // even column
                    end
                end
                default: begin
                    mask[x_port] = 1'b1;   // XY, x first
                end
            endcase
        end
    end

    assign ports  = mask;
    assign code.x = dir.x_plus;
    assign code.y = dir.y_min;
    assign code.a = mask[EAST] | mask[WEST];
    assign code.b = mask[NORTH] | mask[SOUTH];

endmodule

`default_nettype wire

//--- source/route_lane.sv
`default_nettype none

module route_lane #(
    parameter int ni_routing = 0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  load,
    input  route_pkg::route_req_t req,
    input  logic                  release_lane,
    output logic                  busy,
    output logic                  done,
    output route_pkg::route_rsp_t rsp
);
    import mesh_pkg::*;
    import route_pkg::*;

    lane_state_e      state;
    logic             stage2;     // stage 1 holds valid operands
    route_req_t       req_q;      // request as loaded
    dir_t             dir_next;
    algo_e            s1_algo;
    coord_t           s1_cur_x;
    coord_t           s1_dst_x;
    dir_t             s1_dir;
    logic [TAG_W-1:0] s1_tag;
    port_mask_t       algo_ports;
    dest_code_t       algo_code;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= LANE_IDLE;
            stage2 <= 1'b0;
        end else begin
            case (state)
                LANE_IDLE: if (load) state <= LANE_CALC;
                LANE_CALC: begin
                    stage2 <= !stage2;
                    if (stage2) state <= LANE_DONE;
                end
                LANE_DONE: if (release_lane) state <= LANE_IDLE;
                default:   state <= LANE_IDLE;
            endcase
        end
    end

    // mesh direction of the held request
    always_comb begin
        dir_next.x_plus = (req_q.dst_x > req_q.cur_x);
        dir_next.x_min  = (req_q.dst_x < req_q.cur_x);
        dir_next.y_plus = (req_q.dst_y > req_q.cur_y);
        dir_next.y_min  = (req_q.dst_y < req_q.cur_y);
        dir_next.same_x = (req_q.dst_x == req_q.cur_x);
        dir_next.same_y = (req_q.dst_y == req_q.cur_y);
    end

    always_ff @(posedge clk) begin
        if (load) req_q <= req;   // dispatcher loads idle lanes only
        if (state == LANE_CALC && !stage2) begin
            s1_algo  <= req_q.algo;
            s1_cur_x <= req_q.cur_x;
            s1_dst_x <= req_q.dst_x;
            s1_dir   <= dir_next;
            s1_tag   <= req_q.tag;
        end
        if (state == LANE_CALC && stage2) begin
            rsp.tag   <= s1_tag;
            rsp.ports <= algo_ports;
            rsp.code  <= algo_code;
        end
    end

    route_algo #(
        .ni_routing(ni_routing)
    ) u_algo (
        .algo (s1_algo),
        .cur_x(s1_cur_x),
        .dst_x(s1_dst_x),
        .dir  (s1_dir),
        .ports(algo_ports),
        .code (algo_code)
    );

    assign busy = (state != LANE_IDLE);
    assign done = (state == LANE_DONE);

endmodule

`default_nettype wire

//--- source/route_dispatch.sv
`default_nettype none

module route_dispatch #(
    parameter int n_lanes = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_req,
    output logic               in_ack,
    input  logic [n_lanes-1:0] busy,
    output logic [n_lanes-1:0] load
);
    localparam int PTR_W = (n_lanes > 1) ? $clog2(n_lanes) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(n_lanes - 1);

    logic [PTR_W-1:0] ptr;     // next lane to fill
    logic             accept;

    // new request, ack low, target lane free
    assign accept = in_req && !in_ack && !busy[ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_ack <= 1'b0;
            ptr    <= '0;
        end else if (accept) begin
            in_ack <= 1'b1;
            if (ptr == LAST) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end else if (!in_req) begin
            in_ack <= 1'b0;   // return to zero
        end
    end

    // lane samples in_data on the edge that raises in_ack
    always_comb begin
        load      = '0;
        load[ptr] = accept;
    end

endmodule

`default_nettype wire

//--- source/route_collect.sv
`default_nettype none

module route_collect #(
    parameter int n_lanes = 4
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [n_lanes-1:0]    done,
    input  route_pkg::route_rsp_t lane_rsp [n_lanes],
    output logic [n_lanes-1:0]    release_lane,
    output logic                  out_req,
    output route_pkg::route_rsp_t out_data,
    input  logic                  out_ack
);
    localparam int PTR_W = (n_lanes > 1) ? $clog2(n_lanes) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(n_lanes - 1);

    logic [PTR_W-1:0] ptr;       // lane drained next, follows dispatch order
    logic             present;
    logic             drained;

    // previous cycle fully returned to zero
    assign present = done[ptr] && !out_req && !out_ack;
    assign drained = out_req && out_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_req <= 1'b0;
            ptr     <= '0;
        end else if (present) begin
            out_req <= 1'b1;
        end else if (drained) begin
            out_req <= 1'b0;
            if (ptr == LAST) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (present) out_data <= lane_rsp[ptr];   // held for the whole req phase
    end

    // lane goes idle on the same edge that drops out_req
    always_comb begin
        release_lane      = '0;
        release_lane[ptr] = drained;
    end

endmodule

`default_nettype wire

//--- source/route_unit.sv
`default_nettype none

module route_unit #(
    parameter int n_lanes    = 4,
    parameter int ni_routing = 0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_req,
    input  route_pkg::route_req_t in_data,
    output logic                  in_ack,
    output logic                  out_req,
    output route_pkg::route_rsp_t out_data,
    input  logic                  out_ack
);
    import route_pkg::*;

    logic [n_lanes-1:0] busy;
    logic [n_lanes-1:0] done;
    logic [n_lanes-1:0] load;
    logic [n_lanes-1:0] release_lane;
    route_rsp_t         lane_rsp [n_lanes];

    route_dispatch #(
        .n_lanes(n_lanes)
    ) u_dispatch (
        .clk   (clk),
        .arst_n(arst_n),
        .in_req(in_req),
        .in_ack(in_ack),
        .busy  (busy),
        .load  (load)
    );

    // in_data goes to every lane, only the loaded one keeps it
    for (genvar i = 0; i < n_lanes; i++) begin : g_lane
        route_lane #(
            .ni_routing(ni_routing)
        ) u_lane (
            .clk         (clk),
            .arst_n      (arst_n),
            .load        (load[i]),
            .req         (in_data),
            .release_lane(release_lane[i]),
            .busy        (busy[i]),
            .done        (done[i]),
            .rsp         (lane_rsp[i])
        );
    end

    route_collect #(
        .n_lanes(n_lanes)
    ) u_collect (
        .clk         (clk),
        .arst_n      (arst_n),
        .done        (done),
        .lane_rsp    (lane_rsp),
        .release_lane(release_lane),
        .out_req     (out_req),
        .out_data    (out_data),
        .out_ack     (out_ack)
    );

endmodule

`default_nettype wire

//--- dv/route_unit_props.sv
`default_nettype none

module route_unit_props (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  in_req,
    input logic                  in_ack,
    input logic                  out_req,
    input logic                  out_ack,
    input route_pkg::route_rsp_t out_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // input side four-phase protocol
    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose while in_req was low");

    ack_falls_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(in_ack) |-> !$past(in_req))
        else $error("in_ack fell while in_req was still high");

    // output side, data held for the whole req phase
    out_data_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_req && $past(out_req) |-> $stable(out_data))
        else $error("out_data changed while out_req was high");

    out_req_after_ack_low: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> !$past(out_ack))
        else $error("out_req rose before out_ack returned low");

    // every response permits at least one port
    ports_not_empty: assert property (@(posedge clk) disable iff (!arst_n)
        out_req |-> out_data.ports != '0)
        else $error("response with an empty port mask");

endmodule

bind route_unit route_unit_props u_props (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_data(out_data)
);

`default_nettype wire

//--- dv/route_unit_tb.sv
`default_nettype none

module route_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mesh_pkg::*;
    import route_pkg::*;

    localparam int N_LANES      = 4;
    localparam int ACK_TIMEOUT  = 100;    // cycles
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int STALL_CYCLES = 20;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       in_req;
    route_req_t in_data;
    logic       in_ack;
    logic       out_req;
    route_rsp_t out_data;
    logic       out_ack = 1'b0;   // driven by the response checker

    logic             hold_ack;        // withholds out_ack
    logic             timed_out;       // a handshake wait gave up
    logic [TAG_W-1:0] tag_cnt;
    route_rsp_t       exp_q [$];
    int               checks;          // main process counters
    int               errors;
    int               rsp_checks;      // response checker counters
    int               rsp_errors;
    int               received;

    route_unit #(
        .n_lanes   (N_LANES),
        .ni_routing(0)
    ) UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_req  (in_req),
        .in_data (in_data),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_data(out_data),
        .out_ack (out_ack)
    );

    always #10 clk = ~clk;

    // {x, y, a, b} from the coordinates and a port mask
    function automatic dest_code_t code_rule(route_req_t r, port_mask_t m);
        dest_code_t c;
        c.x = (r.dst_x > r.cur_x);
        c.y = (r.dst_y < r.cur_y);   // y grows toward south
        c.a = m[EAST] | m[WEST];
        c.b = m[NORTH] | m[SOUTH];
        return c;
    endfunction

    function automatic port_mask_t two_ports(port_e p, port_e q);
        port_mask_t m;
        m    = '0;
        m[p] = 1'b1;
        m[q] = 1'b1;
        return m;
    endfunction

    // expected response for ni_routing = 0
    function automatic route_rsp_t expected_route(route_req_t r);
        int         dx;
        int         dy;
        port_e      xp;
        port_e      yp;
        port_mask_t m;
        route_rsp_t e;
        dx = int'(r.dst_x) - int'(r.cur_x);
        dy = int'(r.dst_y) - int'(r.cur_y);
        xp = (dx > 0) ? EAST : WEST;
        yp = (dy > 0) ? SOUTH : NORTH;
        m  = '0;
        if (dx == 0 && dy == 0) m = two_ports(LOCAL, LOCAL);
        else if (dx == 0) m = two_ports(yp, yp);
        else if (dy == 0) m = two_ports(xp, xp);
        else begin
            case (r.algo)
                ALGO_WEST_FIRST: m = (dx < 0) ? two_ports(WEST, WEST) : two_ports(EAST, yp);
                ALGO_NORTH_LAST: begin
                    if (dx < 0) m = (dy < 0) ? two_ports(WEST, WEST) : two_ports(WEST, SOUTH);
                    else m = (dy < 0) ? two_ports(EAST, EAST) : two_ports(EAST, SOUTH);
                end
                ALGO_NEG_FIRST: begin
                    if (dx < 0) m = (dy < 0) ? two_ports(WEST, WEST) : two_ports(WEST, SOUTH);
                    else m = (dy < 0) ? two_ports(EAST, NORTH) : two_ports(SOUTH, SOUTH);
                end
                ALGO_ODD_EVEN: begin
                    if (dx > 0) begin
                        if (r.cur_x[0]) m[yp] = 1'b1;
                        if (r.dst_x[0] || dx != 1) m[EAST] = 1'b1;
                    end else begin
                        m[WEST] = 1'b1;
                        if (!r.cur_x[0]) m[yp] = 1'b1;
                    end
                end
                default: m = two_ports(xp, xp);   // XY
            endcase
        end
        e.tag   = r.tag;
        e.ports = m;
        e.code  = code_rule(r, m);
        return e;
    endfunction

    function automatic route_req_t make_req(algo_e a, int cx, int cy, int dx, int dy);
        route_req_t r;
        r.algo  = a;
        r.cur_x = coord_t'(cx);
        r.cur_y = coord_t'(cy);
        r.dst_x = coord_t'(cx + dx);
        r.dst_y = coord_t'(cy + dy);
        r.tag   = '0;
        return r;
    endfunction

    task automatic finish_run();
        $display("checks %0d, errors %0d, responses %0d",
                 checks + rsp_checks, errors + rsp_errors, received);
        if (errors + rsp_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic note_timeout(string what);
        $display("timeout: %s", what);
        errors++;
        timed_out = 1'b1;   // later waits return at once
    endtask

    task automatic start_request(route_req_t r);
        @(negedge clk);
        r.tag   = tag_cnt;
        tag_cnt = tag_cnt + 1'b1;
        in_data = r;
        in_req  = 1'b1;
    endtask

    // wait for ack, log the expected response, return to zero
    task automatic finish_request();
        int n;
        n = 0;
        while (!in_ack && !timed_out && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!in_ack && !timed_out) note_timeout("in_ack never rose for a pending request");
        exp_q.push_back(expected_route(in_data));
        in_req = 1'b0;
        n = 0;
        while (in_ack && !timed_out && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (in_ack && !timed_out) note_timeout("in_ack stayed high after in_req dropped");
    endtask

    task automatic send_request(route_req_t r);
        start_request(r);
        finish_request();
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 && !timed_out && n < DRAIN_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0 && !timed_out) note_timeout("responses still outstanding");
    endtask

    task automatic report_test(int num, string name, int err_before);
        $display("test %0d %s: %0d errors", num, name, errors + rsp_errors - err_before);
    endtask

    task automatic check_response(route_rsp_t got);
        route_rsp_t exp;
        if (exp_q.size() == 0) begin
            $display("response with tag %0d arrived with no request outstanding", got.tag);
            rsp_errors++;
        end else begin
            exp = exp_q.pop_front();
            rsp_checks += 3;
            received++;
            assert (got.tag == exp.tag) else begin
                $display("ERROR %0t: out_data.tag got %0d expected %0d", $time, got.tag, exp.tag);
                rsp_errors++;
            end
            assert (got.ports == exp.ports) else begin
                $display("ERROR %0t: out_data.ports got %b expected %b",
                         $time, got.ports, exp.ports);
                rsp_errors++;
            end
            // code rule applied to the request and its expected mask
            assert (got.code == exp.code) else begin
                $display("ERROR %0t: out_data.code got %b expected %b",
                         $time, got.code, exp.code);
                rsp_errors++;
            end
        end
    endtask

    // response side consumer and checker
    always @(negedge clk) begin
        if (!arst_n) begin
            out_ack = 1'b0;
        end else if (out_req && !out_ack && !hold_ack) begin
            check_response(out_data);
            out_ack = 1'b1;
        end else if (!out_req && out_ack) begin
            out_ack = 1'b0;
        end
    end

    initial begin
        int         err_before;
        logic [31:0] rnd;
        route_req_t r;
        void'($urandom(32'h8526_adf6));
        arst_n     = 1'b0;
        in_req     = 1'b0;
        in_data    = '0;
        hold_ack   = 1'b0;
        timed_out  = 1'b0;
        tag_cnt    = '0;
        checks     = 0;
        errors     = 0;
        rsp_checks = 0;
        rsp_errors = 0;
        received   = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        err_before = 0;
        @(negedge clk);
        checks += 2;
        assert (!in_ack) else begin
            $display("ERROR %0t: in_ack got %b expected 0", $time, in_ack);
            errors++;
        end
        assert (!out_req) else begin
            $display("ERROR %0t: out_req got %b expected 0", $time, out_req);
            errors++;
        end
        report_test(1, "reset values", err_before);

        // LOCAL, straight and diagonal moves from an odd and an even column
        err_before = errors + rsp_errors;
        for (int a = 0; a < 5; a++) begin
            for (int c = 3; c <= 4; c++) begin
                for (int dx = -2; dx <= 2; dx += 2) begin
                    for (int dy = -2; dy <= 2; dy += 2) begin
                        send_request(make_req(algo_e'(3'(a)), c, c, dx, dy));
                    end
                end
            end
        end
        wait_drained();
        report_test(2, "directed corner cases", err_before);

        err_before = errors + rsp_errors;
        for (int c = 2; c <= 3; c++) begin
            for (int dx = -2; dx <= 2; dx++) begin
                for (int dy = -1; dy <= 1; dy += 2) begin
                    if (dx != 0) send_request(make_req(ALGO_ODD_EVEN, c, 3, dx, dy));
                end
            end
        end
        wait_drained();
        report_test(3, "odd-even diagonals", err_before);

        err_before = errors + rsp_errors;
        for (int i = 0; i < 300; i++) begin
            rnd     = $urandom;
            r.algo  = algo_e'(3'(rnd % 5));
            rnd     = $urandom;
            r.cur_x = rnd[2:0];
            r.cur_y = rnd[5:3];
            r.dst_x = rnd[8:6];
            r.dst_y = rnd[11:9];
            r.tag   = '0;
            send_request(r);
        end
        wait_drained();
        report_test(4, "random traffic", err_before);

        // lanes fill while out_ack is withheld
        err_before = errors + rsp_errors;
        hold_ack   = 1'b1;
        for (int i = 0; i < N_LANES; i++) begin
            send_request(make_req(algo_e'(3'(i % 5)), 1, 6, 4, -3));
        end
        start_request(make_req(ALGO_ODD_EVEN, 5, 2, -3, 4));
        for (int i = 0; i < STALL_CYCLES; i++) begin
            @(negedge clk);
            checks++;
            assert (!in_ack) else begin
                $display("ERROR %0t: in_ack got %b expected 0", $time, in_ack);
                errors++;
            end
        end
        hold_ack = 1'b0;
        finish_request();
        send_request(make_req(ALGO_NEG_FIRST, 2, 2, 3, -1));
        wait_drained();
        report_test(5, "back-pressure", err_before);

        finish_run();
    end

endmodule

`default_nettype wire

//--- project.f
source/mesh_pkg.sv
source/route_pkg.sv
source/route_algo.sv
source/route_lane.sv
source/route_dispatch.sv
source/route_collect.sv
source/route_unit.sv
dv/route_unit_props.sv
dv/route_unit_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module route_unit_tb -f project.f -o route_sim \
    && ./obj_dir/route_sim | tee /dev/stderr | grep -q "TEST PASS" \
    || { echo "route_unit simulation failed"; exit 1; }
